// File: bench/soc_testdata.txt
// we addr wdata be exp_rdata chk_rdata exp_err
// SRAM full words, byte enables, control registers, unmapped space
1 10000000 11223344 f 00000000 0 0
1 10000004 55667788 f 00000000 0 0
0 10000000 00000000 0 11223344 1 0
0 10000004 00000000 0 55667788 1 0
1 100007fc cafef00d f 00000000 0 0
0 100007fc 00000000 0 cafef00d 1 0
1 10000000 aabbccdd 5 00000000 0 0
0 10000000 00000000 0 11bb33dd 1 0
1 10000004 ee000000 8 00000000 0 0
0 10000004 00000000 0 ee667788 1 0
0 03000000 00000000 0 10000000 1 0
1 03000000 20000080 f 00000000 0 0
0 03000000 00000000 0 20000080 1 0
1 03000000 0000ab00 2 00000000 0 0
0 03000000 00000000 0 2000ab80 1 0
1 03000004 00000001 1 00000000 0 0
0 03000004 00000000 0 00000001 1 0
0 03000008 00000000 0 00000000 1 1
1 03000ffc 00000000 f 00000000 0 1
0 00000000 00000000 0 badcab1e 1 1
1 20000000 12345678 f 00000000 0 1
0 10000800 00000000 0 badcab1e 1 1
0 03001000 00000000 0 badcab1e 1 1
0 fffffffc 00000000 0 badcab1e 1 1

// File: bench/tb_soc_domain.sv
// Testbench for the SoC data path. Replays the request vectors from the
// test data file, checks every response, its latency and its order,
// and the boot address and fetch enable outputs.

module tb_soc_domain;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          NumVecs       = 24;
  localparam int          VecFields     = 7;
  localparam int          DrainLimit    = 50;
  localparam logic [31:0] ResetBootAddr = 32'h1000_0000;
  localparam logic [31:0] FinalBootAddr = 32'h2000_ab80; // After the register writes in the file

  logic        clk;
  logic        arst_n;
  logic        req;
  logic        we;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic [3:0]  be;
  logic        fetch_en;
  logic        rvalid;
  logic [31:0] rdata;
  logic        err;
  logic        fetch_enable;
  logic [31:0] boot_addr;

  logic [31:0] vec_mem [0:NumVecs*VecFields-1];

  // Expectations in request order
  logic [31:0] exp_rdata_q [$];
  logic        exp_chk_q [$];
  logic        exp_err_q [$];
  int          vec_idx_q [$];
  int          due_q [$];     // Cycle in which the response must show

  int cyc;
  int checks;
  int mismatches;
  int other_errs;

  soc_domain soc_domain_inst (
    .clk_i          ( clk          ),
    .arst_n_i       ( arst_n       ),
    .req_i          ( req          ),
    .we_i           ( we           ),
    .addr_i         ( addr         ),
    .wdata_i        ( wdata        ),
    .be_i           ( be           ),
    .fetch_en_i     ( fetch_en     ),
    .rvalid_o       ( rvalid       ),
    .rdata_o        ( rdata        ),
    .err_o          ( err          ),
    .fetch_enable_o ( fetch_enable ),
    .boot_addr_o    ( boot_addr    )
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Control outputs are sampled away from the rising edge
  task check_ctrl_outputs(input logic [31:0] exp_boot, input logic exp_fetch,
                          input string what);
    checks = checks + 1;
    if (boot_addr !== exp_boot) begin
      $display("mismatch at %0t: %s boot_addr_o %h, expected %h", $time, what, boot_addr,
               exp_boot);
      mismatches = mismatches + 1;
    end
    if (fetch_enable !== exp_fetch) begin
      $display("mismatch at %0t: %s fetch_enable_o %b, expected %b", $time, what,
               fetch_enable, exp_fetch);
      mismatches = mismatches + 1;
    end
  endtask

  // --------------------
  // Response monitor
  // --------------------
  always @(negedge clk) begin : monitor
    logic [31:0] exp_rdata;
    logic        exp_chk;
    logic        exp_err;
    int          vec_idx;
    int          due;

    cyc = cyc + 1;
    if (arst_n) begin
      if (due_q.size() != 0 && due_q[0] == cyc && !rvalid) begin
        $display("Response for vector %0d did not arrive at %0t", vec_idx_q[0], $time);
        other_errs = other_errs + 1;
        void'(due_q.pop_front());
        void'(exp_rdata_q.pop_front());
        void'(exp_chk_q.pop_front());
        void'(exp_err_q.pop_front());
        void'(vec_idx_q.pop_front());
      end else if (rvalid) begin
        if (due_q.size() == 0 || exp_rdata_q.size() == 0) begin
          $display("Response at %0t with no request outstanding", $time);
          other_errs = other_errs + 1;
        end else begin
          due       = due_q.pop_front();
          exp_rdata = exp_rdata_q.pop_front();
          exp_chk   = exp_chk_q.pop_front();
          exp_err   = exp_err_q.pop_front();
          vec_idx   = vec_idx_q.pop_front();
          checks    = checks + 1;
          if (due != cyc) begin
            $display("mismatch at %0t: vector %0d answered in cycle %0d, expected %0d",
                     $time, vec_idx, cyc, due);
            mismatches = mismatches + 1;
          end
          if (err !== exp_err) begin
            $display("mismatch at %0t: vector %0d err_o %b, expected %b", $time, vec_idx,
                     err, exp_err);
            mismatches = mismatches + 1;
          end
          if (exp_chk && rdata !== exp_rdata) begin
            $display("mismatch at %0t: vector %0d rdata_o %h, expected %h", $time, vec_idx,
                     rdata, exp_rdata);
            mismatches = mismatches + 1;
          end
        end
      end
      // Sampled at the next rising edge and answered two edges later
      if (req) due_q.push_back(cyc + 2);
    end
  end

  // --------------------
  // Stimulus
  // --------------------
  initial begin : driver
    int base;
    int gap;
    int wait_cnt;

    arst_n     = 1'b0;
    req        = 1'b0;
    we         = 1'b0;
    addr       = '0;
    wdata      = '0;
    be         = '0;
    fetch_en   = 1'b0;
    cyc        = 0;
    checks     = 0;
    mismatches = 0;
    other_errs = 0;
    void'($urandom(6));

    $readmemh("bench/soc_testdata.txt", vec_mem);
    if ($isunknown(vec_mem[NumVecs*VecFields-1])) begin
      $display("Test data file is missing or shorter than %0d vectors", NumVecs);
      other_errs = other_errs + 1;
    end

    repeat (10) @(posedge clk);
    arst_n <= 1'b1;

    // Reset state and the fetch enable pin
    @(negedge clk);
    check_ctrl_outputs(ResetBootAddr, 1'b0, "after reset");
    @(posedge clk);
    fetch_en <= 1'b1;
    @(negedge clk);
    check_ctrl_outputs(ResetBootAddr, 1'b1, "pin high");
    @(posedge clk);
    fetch_en <= 1'b0;
    @(negedge clk);
    check_ctrl_outputs(ResetBootAddr, 1'b0, "pin low");

    for (int i = 0; i < NumVecs; i++) begin
      base = i * VecFields;
      @(posedge clk);
      req   <= 1'b1;
      we    <= vec_mem[base][0];
      addr  <= vec_mem[base+1];
      wdata <= vec_mem[base+2];
      be    <= vec_mem[base+3][3:0];
      exp_rdata_q.push_back(vec_mem[base+4]);
      exp_chk_q.push_back(vec_mem[base+5][0]);
      exp_err_q.push_back(vec_mem[base+6][0]);
      vec_idx_q.push_back(i);
      if ($urandom % 4 == 0) begin
        gap = 1 + $urandom % 2;
        repeat (gap) begin
          @(posedge clk);
          req <= 1'b0;
        end
      end
    end
    @(posedge clk);
    req <= 1'b0;

    wait_cnt = 0;
    while (exp_rdata_q.size() != 0 && wait_cnt < DrainLimit) begin
      @(posedge clk);
      wait_cnt = wait_cnt + 1;
    end
    if (exp_rdata_q.size() != 0) begin
      $display("Timed out with %0d responses still outstanding", exp_rdata_q.size());
      other_errs = other_errs + 1;
    end

    @(negedge clk);
    check_ctrl_outputs(FinalBootAddr, 1'b1, "after register writes");

    $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, other_errs);
    if (mismatches == 0 && other_errs == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: logic/addr_decode_stage.sv
// First pipeline stage. Samples every bus request, works out which
// subordinate owns the address and hands both on to the access stage.

module addr_decode_stage (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          req_i,
  input  logic                          we_i,
  input  logic [soc_pkg::AddrWidth-1:0] addr_i,
  input  logic [soc_pkg::DataWidth-1:0] wdata_i,
  input  logic [soc_pkg::BeWidth-1:0]   be_i,
  obi_stage_if.decode                   stage_o
);

  logic             in_sram;
  logic             in_soc_ctrl;
  soc_pkg::target_e target_d;

  assign in_sram = (addr_i >= soc_pkg::SramBaseAddr) &&
                   (addr_i < soc_pkg::SramBaseAddr + soc_pkg::SramNumWords * soc_pkg::BeWidth);
  assign in_soc_ctrl = (addr_i >= soc_pkg::SocCtrlBaseAddr) &&
                       (addr_i < soc_pkg::SocCtrlBaseAddr + soc_pkg::SocCtrlSize);

  always_comb begin
    if (in_sram) begin
      target_d = soc_pkg::TgtSram;
    end else if (in_soc_ctrl) begin
      target_d = soc_pkg::TgtSocCtrl;
    end else begin
      target_d = soc_pkg::TgtError; // Unmapped space
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      stage_o.valid <= 1'b0;
    end else begin
      stage_o.valid <= req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      stage_o.we     <= we_i;
      stage_o.addr   <= addr_i;
      stage_o.wdata  <= wdata_i;
      stage_o.be     <= be_i;
      stage_o.target <= target_d;
    end
  end

  // Subordinates and response mux all rely on a known target
  a_target_known: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    stage_o.valid |-> !$isunknown(stage_o.target)
  ) else $error("decoded target unknown on a valid request");

endmodule

// File: logic/obi_stage_if.sv
// Request handed from the decode stage to the access stage.
// The decode side drives every signal, the subordinates only listen.

interface obi_stage_if;

  logic                             valid;
  logic                             we;
  soc_pkg::bus_addr_u               addr;
  logic [soc_pkg::DataWidth-1:0]    wdata;
  logic [soc_pkg::BeWidth-1:0]      be;
  soc_pkg::target_e                 target;

  modport decode (
    output valid, we, addr, wdata, be, target
  );

  modport access (
    input  valid, we, addr, wdata, be, target
  );

endinterface

// File: logic/rsp_mux_stage.sv
// Response stage. Follows each request by one cycle, picks the answering
// subordinate and doubles as the error subordinate for unmapped space.

module rsp_mux_stage (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  obi_stage_if.access                   stage_i,
  input  logic [soc_pkg::DataWidth-1:0] sram_rdata_i,
  input  logic [soc_pkg::DataWidth-1:0] reg_rdata_i,
  input  logic                          reg_err_i,
  output logic                          rvalid_o,
  output logic [soc_pkg::DataWidth-1:0] rdata_o,
  output logic                          err_o
);

  logic             valid_q;
  soc_pkg::target_e target_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= stage_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (stage_i.valid) begin
      target_q <= stage_i.target;
    end
  end

  always_comb begin
    case (target_q)
      soc_pkg::TgtSram: begin
        rdata_o = sram_rdata_i;
        err_o   = 1'b0;
      end
      soc_pkg::TgtSocCtrl: begin
        rdata_o = reg_rdata_i;
        err_o   = reg_err_i;
      end
      default: begin
        rdata_o = soc_pkg::ErrRspData; // Error subordinate
        err_o   = 1'b1;
      end
    endcase
  end

  assign rvalid_o = valid_q;

  a_rvalid_known: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    !$isunknown(rvalid_o)
  ) else $error("response valid unknown after reset");

endmodule

// File: logic/soc_ctrl_regs.sv
// SoC control registers: boot address and fetch enable.
// Accessed from the stage bus, with an error for unused offsets.

module soc_ctrl_regs (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  obi_stage_if.access                   stage_i,
  output logic [soc_pkg::DataWidth-1:0] reg_rdata_o,
  output logic                          reg_err_o,
  output logic [soc_pkg::AddrWidth-1:0] boot_addr_o,
  output logic                          fetch_en_reg_o
);

  logic                            access;
  logic [soc_pkg::RegIdxWidth-1:0] reg_idx;
  logic [soc_pkg::AddrWidth-1:0]   boot_addr_q;
  logic                            fetch_en_q;
  logic [soc_pkg::DataWidth-1:0]   rdata_d;
  logic                            err_d;

  assign access  = stage_i.valid && (stage_i.target == soc_pkg::TgtSocCtrl);
  assign reg_idx = stage_i.addr.regs.reg_idx;

  // --------------------
  // Register writes
  // --------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      boot_addr_q <= soc_pkg::SramBaseAddr;
      fetch_en_q  <= 1'b0;
    end else if (access && stage_i.we) begin
      if (reg_idx == soc_pkg::RegBootAddrIdx) begin
        for (int b = 0; b < soc_pkg::BeWidth; b++) begin
          if (stage_i.be[b]) begin
            boot_addr_q[b*8 +: 8] <= stage_i.wdata[b*8 +: 8];
          end
        end
      end else if ((reg_idx == soc_pkg::RegFetchEnIdx) && stage_i.be[0]) begin
        fetch_en_q <= stage_i.wdata[0];
      end
    end
  end

  // --------------------
  // Read back
  // --------------------
  always_comb begin
    rdata_d = '0;
    err_d   = 1'b0;
    case (reg_idx)
      soc_pkg::RegBootAddrIdx: rdata_d = boot_addr_q;
      soc_pkg::RegFetchEnIdx:  rdata_d = {{(soc_pkg::DataWidth-1){1'b0}}, fetch_en_q};
      default:                 err_d   = 1'b1; // Hole in the region
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      reg_rdata_o <= rdata_d;
      reg_err_o   <= err_d;
    end
  end

  assign boot_addr_o    = boot_addr_q;
  assign fetch_en_reg_o = fetch_en_q;

endmodule

// File: logic/soc_domain.sv
// Memory-mapped data path of the SoC domain. One bus manager drives the
// plain request ports; responses return two cycles later in order.

module soc_domain (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  input  logic                          req_i,
  input  logic                          we_i,
  input  logic [soc_pkg::AddrWidth-1:0] addr_i,
  input  logic [soc_pkg::DataWidth-1:0] wdata_i,
  input  logic [soc_pkg::BeWidth-1:0]   be_i,
  input  logic                          fetch_en_i,
  output logic                          rvalid_o,
  output logic [soc_pkg::DataWidth-1:0] rdata_o,
  output logic                          err_o,
  output logic                          fetch_enable_o,
  output logic [soc_pkg::AddrWidth-1:0] boot_addr_o
);

  logic [soc_pkg::DataWidth-1:0] sram_rdata;
  logic [soc_pkg::DataWidth-1:0] reg_rdata;
  logic                          reg_err;
  logic                          fetch_en_reg;

  obi_stage_if stage_bus ();

  // --------------------
  // Decode
  // --------------------
  addr_decode_stage i_addr_decode (
    .clk_i    ( clk_i     ),
    .arst_n_i ( arst_n_i  ),
    .req_i    ( req_i     ),
    .we_i     ( we_i      ),
    .addr_i   ( addr_i    ),
    .wdata_i  ( wdata_i   ),
    .be_i     ( be_i      ),
    .stage_o  ( stage_bus )
  );

  // --------------------
  // Access
  // --------------------
  sram_bank i_sram_bank (
    .clk_i        ( clk_i      ),
    .arst_n_i     ( arst_n_i   ),
    .stage_i      ( stage_bus  ),
    .sram_rdata_o ( sram_rdata )
  );

  soc_ctrl_regs i_soc_ctrl (
    .clk_i          ( clk_i        ),
    .arst_n_i       ( arst_n_i     ),
    .stage_i        ( stage_bus    ),
    .reg_rdata_o    ( reg_rdata    ),
    .reg_err_o      ( reg_err      ),
    .boot_addr_o    ( boot_addr_o  ),
    .fetch_en_reg_o ( fetch_en_reg )
  );

  // --------------------
  // Response
  // --------------------
  rsp_mux_stage i_rsp_mux (
    .clk_i        ( clk_i      ),
    .arst_n_i     ( arst_n_i   ),
    .stage_i      ( stage_bus  ),
    .sram_rdata_i ( sram_rdata ),
    .reg_rdata_i  ( reg_rdata  ),
    .reg_err_i    ( reg_err    ),
    .rvalid_o     ( rvalid_o   ),
    .rdata_o      ( rdata_o    ),
    .err_o        ( err_o      )
  );

  assign fetch_enable_o = fetch_en_reg | fetch_en_i; // Pin can force fetch

endmodule

// File: logic/soc_pkg.sv
// Shared definitions for the SoC data path: bus widths, address map,
// control register offsets, subordinate targets and the address views.
// Referenced by scoped name from every module of the design.

package soc_pkg;

  // --------------------
  // Bus widths
  // --------------------
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned BeWidth   = 4;

  // --------------------
  // Address map
  // --------------------
  localparam logic [AddrWidth-1:0] SramBaseAddr      = 32'h1000_0000; // Also boot address reset
  localparam int unsigned          SramNumWords      = 512;
  localparam int unsigned          SramWordAddrWidth = 9;

  localparam logic [AddrWidth-1:0] SocCtrlBaseAddr = 32'h0300_0000;
  localparam logic [AddrWidth-1:0] SocCtrlSize     = 32'h0000_1000;

  // Control register word offsets
  localparam int unsigned            RegIdxWidth    = 10;
  localparam logic [RegIdxWidth-1:0] RegBootAddrIdx = 10'd0;
  localparam logic [RegIdxWidth-1:0] RegFetchEnIdx  = 10'd1;

  localparam logic [DataWidth-1:0] ErrRspData = 32'hBADC_AB1E;

  // Which subordinate answers a request
  typedef enum logic [1:0] {
    TgtSram,
    TgtSocCtrl,
    TgtError
  } target_e;

  // Same address word, split for the SRAM or for the register block
  typedef union packed {
    struct packed {
      logic [AddrWidth-SramWordAddrWidth-3:0] upper;
      logic [SramWordAddrWidth-1:0]           word_idx;
      logic [1:0]                             byte_off;
    } sram;
    struct packed {
      logic [AddrWidth-RegIdxWidth-3:0] upper;
      logic [RegIdxWidth-1:0]           reg_idx;
      logic [1:0]                       byte_off;
    } regs;
  } bus_addr_u;

endpackage

// File: logic/sram_bank.sv
// Single-port SRAM bank on the access stage with byte-enabled writes.
// Reads come out registered one cycle later.

module sram_bank (
  input  logic                          clk_i,
  input  logic                          arst_n_i,
  obi_stage_if.access                   stage_i,
  output logic [soc_pkg::DataWidth-1:0] sram_rdata_o
);

  logic [soc_pkg::DataWidth-1:0]         mem_q [soc_pkg::SramNumWords];
  logic                                  access;
  logic [soc_pkg::SramWordAddrWidth-1:0] word_idx;

  assign access   = stage_i.valid && (stage_i.target == soc_pkg::TgtSram);
  assign word_idx = stage_i.addr.sram.word_idx;

  always_ff @(posedge clk_i) begin
    if (access) begin
      if (stage_i.we) begin
        for (int b = 0; b < soc_pkg::BeWidth; b++) begin
          if (stage_i.be[b]) begin
            mem_q[word_idx][b*8 +: 8] <= stage_i.wdata[b*8 +: 8];
          end
        end
      end else begin
        sram_rdata_o <= mem_q[word_idx];
      end
    end
  end

  // Decoder must only route addresses that land inside the bank
  a_word_in_range: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    access |-> (stage_i.addr >= soc_pkg::SramBaseAddr) &&
               (stage_i.addr < soc_pkg::SramBaseAddr +
                               soc_pkg::SramNumWords * soc_pkg::BeWidth)
  ) else $error("SRAM accessed outside its word range");

endmodule

// File: sim.f
logic/soc_pkg.sv
logic/obi_stage_if.sv
logic/addr_decode_stage.sv
logic/sram_bank.sv
logic/soc_ctrl_regs.sv
logic/rsp_mux_stage.sv
logic/soc_domain.sv
bench/tb_soc_domain.sv
